//--- verilog/lc3b_pkg.sv
package lc3b_pkg;

    localparam int word_width = 16;
    localparam int opcode_width = 4;
    localparam int aluop_width = 3;
    localparam int reg_width = 3;
    localparam int nzp_width = 3;
    localparam int addr2_sel_width = 2;

    typedef logic [word_width-1:0] lc3b_word;
    typedef logic [reg_width-1:0] lc3b_reg;
    typedef logic [nzp_width-1:0] lc3b_nzp;

    // Encodings follow the LC-3b ISA, ir[15:12].
    typedef enum logic [opcode_width-1:0]
    {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [aluop_width-1:0]
    {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // Offset fed to the address adder.
    typedef enum logic [addr2_sel_width-1:0]
    {
        a2_zero  = 2'b00,
        a2_off6  = 2'b01,
        a2_off9  = 2'b10,
        a2_off11 = 2'b11
    } addr2_sel_t;

endpackage : lc3b_pkg

//--- verilog/lc3b_decode.sv
`timescale 1ns/1ns

module lc3b_decode import lc3b_pkg::*;
(
    input lc3b_word ir,

    output lc3b_opcode opcode,
    output lc3b_aluop aluop,
    output logic sr2_sel,
    output logic addr1_sel,
    output logic trap_sel,
    output logic lshf_enable,
    output logic mem_read,
    output logic mem_write,
    output logic load_cc,
    output logic load_regfile,
    output logic branch,
    output addr2_sel_t addr2_sel,
    output lc3b_reg dr
);

assign opcode = lc3b_opcode'(ir[15:12]);

always_comb
begin
    aluop = alu_pass;
    sr2_sel = 1'b0;
    addr1_sel = 1'b0;
    trap_sel = 1'b0;
    lshf_enable = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    load_cc = 1'b0;
    load_regfile = 1'b0;
    branch = 1'b0;
    addr2_sel = a2_zero;
    dr = ir[11:9];

    case (opcode)
        op_add, op_and:
        begin
            aluop = (opcode == op_add) ? alu_add : alu_and;
            // Bit 5 picks imm5 over SR2.
            sr2_sel = ir[5];
            load_cc = 1'b1;
            load_regfile = 1'b1;
        end
        op_not:
        begin
            aluop = alu_not;
            load_cc = 1'b1;
            load_regfile = 1'b1;
        end
        op_shf:
        begin
            if (!ir[4])
                aluop = alu_sll;
            else if (!ir[5])
                aluop = alu_srl;
            else
                aluop = alu_sra;
            load_cc = 1'b1;
            load_regfile = 1'b1;
        end
        op_br:
        begin
            branch = 1'b1;
            addr2_sel = a2_off9;
            lshf_enable = 1'b1;
        end
        op_jmp:
        begin
            branch = 1'b1;
            addr1_sel = 1'b1;
        end
        op_jsr:
        begin
            // JSR is PC relative, JSRR takes the base register.
            branch = 1'b1;
            load_regfile = 1'b1;
            addr1_sel = ~ir[11];
            addr2_sel = ir[11] ? a2_off11 : a2_zero;
            lshf_enable = 1'b1;
            dr = 3'd7;
        end
        op_ldb, op_ldr, op_ldi:
        begin
            mem_read = 1'b1;
            load_cc = 1'b1;
            load_regfile = 1'b1;
            addr1_sel = 1'b1;
            addr2_sel = a2_off6;
            lshf_enable = (opcode != op_ldb);
        end
        op_stb, op_str:
        begin
            mem_write = 1'b1;
            addr1_sel = 1'b1;
            addr2_sel = a2_off6;
            lshf_enable = (opcode == op_str);
        end
        op_sti:
        begin
            // First access only reads the pointer.
            mem_read = 1'b1;
            addr1_sel = 1'b1;
            addr2_sel = a2_off6;
            lshf_enable = 1'b1;
        end
        op_lea:
        begin
            load_regfile = 1'b1;
            addr2_sel = a2_off9;
            lshf_enable = 1'b1;
        end
        op_trap:
        begin
            trap_sel = 1'b1;
            mem_read = 1'b1;
            branch = 1'b1;
            load_regfile = 1'b1;
            dr = 3'd7;
        end
        default:
        begin
            // RTI is treated as a no-op here.
            aluop = alu_pass;
        end
    endcase
end

endmodule : lc3b_decode

//--- verilog/lc3b_stage_reg.sv
`timescale 1ns/1ns

module lc3b_stage_reg
#(
    parameter type payload_t = logic
)
(
    input logic clk,
    input logic reset,
    input logic hold,
    input payload_t d,
    output payload_t q
);

always_ff @(posedge clk)
begin
    if (reset)
        q <= '0;
    else if (!hold)
        q <= d;
end

// A held stage must not move on the following edge.
hold_keeps_q: assert property (@(posedge clk) disable iff (reset)
    (hold && !reset) |=> $stable(q));

endmodule : lc3b_stage_reg

//--- verilog/lc3b_alu.sv
`timescale 1ns/1ns

module lc3b_alu import lc3b_pkg::*;
#(
    parameter int width = 16
)
(
    input lc3b_aluop aluop,
    input logic [width-1:0] a,
    input logic [width-1:0] b,
    output logic [width-1:0] f
);

logic [3:0] shamt;

assign shamt = b[3:0];

always_comb
begin
    case (aluop)
        alu_add:
            f = a + b;
        alu_and:
            f = a & b;
        alu_not:
            f = ~a;
        alu_sll:
            f = a << shamt;
        alu_srl:
            f = a >> shamt;
        alu_sra:
            f = $unsigned($signed(a) >>> shamt);
        default:
            f = a;
    endcase
end

endmodule : lc3b_alu

//--- verilog/lc3b_execute.sv
`timescale 1ns/1ns

module lc3b_execute import lc3b_pkg::*;
#(
    parameter int width = 16
)
(
    input logic clk,
    input logic reset,
    input logic stall,

    input lc3b_opcode opcode,
    input logic sr2_sel,
    input logic addr1_sel,
    input logic trap_sel,
    input logic lshf_enable,
    input addr2_sel_t addr2_sel,
    input logic mem_read,
    input logic mem_write,
    input logic load_cc,
    input logic load_regfile,
    input logic branch,
    input lc3b_reg dr,
    input lc3b_word ir,
    input logic [width-1:0] npc,
    input logic [width-1:0] sr1,
    input logic [width-1:0] sr2,
    input lc3b_nzp cc,
    input logic indirect,
    input logic valid_in,
    input logic [width-1:0] alu_result,

    output logic [width-1:0] alu_b,
    output logic [width-1:0] address,

    output lc3b_opcode rw_opcode,
    output addr2_sel_t rw_addr2_sel,
    output logic rw_mem_read,
    output logic rw_mem_write,
    output logic rw_load_cc,
    output logic rw_load_regfile,
    output logic rw_indirect,
    output logic rewrite_en,
    output logic ex_indirect_stall,

    output logic ex_valid,
    output lc3b_opcode ex_opcode,
    output logic ex_mem_read,
    output logic ex_mem_write,
    output logic ex_indirect,
    output logic ex_load_cc,
    output logic ex_load_regfile,
    output logic ex_br_request,
    output lc3b_reg ex_dr,
    output logic [width-1:0] ex_result,
    output logic [width-1:0] ex_npc,
    output lc3b_nzp ex_cc
);

logic [width-1:0] base;
logic [width-1:0] offset;
logic [width-1:0] offset_adj;
logic [width-1:0] trap_addr;
logic [width-1:0] imm5;
logic is_indirect_op;

assign base = addr1_sel ? sr1 : npc;
assign trap_addr = {{(width-9){1'b0}}, ir[7:0], 1'b0};
assign imm5 = {{(width-5){ir[4]}}, ir[4:0]};

always_comb
begin
    case (addr2_sel)
        a2_off6:
            offset = {{(width-6){ir[5]}}, ir[5:0]};
        a2_off9:
            offset = {{(width-9){ir[8]}}, ir[8:0]};
        a2_off11:
            offset = {{(width-11){ir[10]}}, ir[10:0]};
        default:
            offset = '0;
    endcase
end

assign offset_adj = lshf_enable ? (offset << 1) : offset;
assign address = trap_sel ? trap_addr : (base + offset_adj);

// Shift amount comes from ir[3:0] for SHF.
always_comb
begin
    if (opcode == op_shf)
        alu_b = {{(width-4){1'b0}}, ir[3:0]};
    else if (sr2_sel)
        alu_b = imm5;
    else
        alu_b = sr2;
end

// An unsplit LDI or STI holds decode for one cycle.
assign is_indirect_op = (opcode == op_ldi) || (opcode == op_sti);
assign ex_indirect_stall = valid_in && is_indirect_op && !indirect;
assign rewrite_en = ex_indirect_stall;

// Second access takes its address from the pointer, so offset is zero.
assign rw_opcode = (opcode == op_ldi) ? op_ldr : op_str;
assign rw_addr2_sel = a2_zero;
assign rw_mem_read = (opcode == op_ldi);
assign rw_mem_write = (opcode == op_sti);
assign rw_load_cc = load_cc;
assign rw_load_regfile = load_regfile;
assign rw_indirect = 1'b1;

assign ex_valid = valid_in;
assign ex_opcode = opcode;
assign ex_indirect = indirect;
assign ex_dr = dr;
assign ex_npc = npc;
assign ex_cc = cc;
assign ex_br_request = valid_in && branch;

always_comb
begin
    if (ex_indirect_stall)
    begin
        // Pointer read writes nothing back.
        ex_mem_read = 1'b1;
        ex_mem_write = 1'b0;
        ex_load_cc = 1'b0;
        ex_load_regfile = 1'b0;
    end
    else
    begin
        ex_mem_read = mem_read;
        ex_mem_write = mem_write;
        ex_load_cc = valid_in && load_cc;
        ex_load_regfile = valid_in && load_regfile;
    end
end

// Link value for JSR and TRAP, the effective address for LEA.
always_comb
begin
    if (opcode == op_jsr || opcode == op_trap)
        ex_result = npc;
    else if (opcode == op_lea)
        ex_result = address;
    else
        ex_result = alu_result;
end

// The rewrite in ID/EX must clear the split after one unstalled cycle.
indirect_split_once: assert property (@(posedge clk) disable iff (reset)
    (ex_indirect_stall && !stall) |=> !ex_indirect_stall);

endmodule : lc3b_execute

//--- verilog/lc3b_ex_pipeline.sv
`timescale 1ns/1ns

module lc3b_ex_pipeline import lc3b_pkg::*;
#(
    parameter int width = 16
)
(
    input logic clk,
    input logic reset,

    input lc3b_word ir,
    input lc3b_word npc,
    input lc3b_word sr1,
    input lc3b_word sr2,
    input lc3b_nzp cc_in,
    input logic valid_in,
    input logic stall,

    output logic valid,
    output lc3b_opcode opcode,
    output logic mem_read,
    output logic mem_write,
    output logic indirect,
    output logic load_cc,
    output logic load_regfile,
    output logic br_request,
    output lc3b_reg dr,
    output lc3b_word result,
    output lc3b_word address,
    output lc3b_word npc_out,
    output lc3b_nzp cc_out,
    output logic ex_indirect_stall
);

typedef struct packed {
    logic valid;
    lc3b_opcode opcode;
    lc3b_aluop aluop;
    logic sr2_sel;
    logic addr1_sel;
    logic trap_sel;
    logic lshf_enable;
    addr2_sel_t addr2_sel;
    logic mem_read;
    logic mem_write;
    logic load_cc;
    logic load_regfile;
    logic branch;
    logic indirect;
    lc3b_reg dr;
    lc3b_word ir;
    logic [width-1:0] npc;
    logic [width-1:0] sr1;
    logic [width-1:0] sr2;
    lc3b_nzp cc;
} id_ex_t;

typedef struct packed {
    logic valid;
    lc3b_opcode opcode;
    logic mem_read;
    logic mem_write;
    logic indirect;
    logic load_cc;
    logic load_regfile;
    logic br_request;
    lc3b_reg dr;
    logic [width-1:0] result;
    logic [width-1:0] address;
    logic [width-1:0] npc;
    lc3b_nzp cc;
} ex_mem_t;

id_ex_t dec;
id_ex_t id_ex_d;
id_ex_t id_ex_q;
ex_mem_t ex_mem_d;
ex_mem_t ex_mem_q;

lc3b_opcode rw_opcode;
addr2_sel_t rw_addr2_sel;
logic rw_mem_read;
logic rw_mem_write;
logic rw_load_cc;
logic rw_load_regfile;
logic rw_indirect;
logic rewrite_en;
logic [width-1:0] alu_b;
logic [width-1:0] alu_result;

lc3b_decode decode
(
    .ir(ir),
    .opcode(dec.opcode),
    .aluop(dec.aluop),
    .sr2_sel(dec.sr2_sel),
    .addr1_sel(dec.addr1_sel),
    .trap_sel(dec.trap_sel),
    .lshf_enable(dec.lshf_enable),
    .mem_read(dec.mem_read),
    .mem_write(dec.mem_write),
    .load_cc(dec.load_cc),
    .load_regfile(dec.load_regfile),
    .branch(dec.branch),
    .addr2_sel(dec.addr2_sel),
    .dr(dec.dr)
);

assign dec.valid = valid_in;
assign dec.indirect = 1'b0;
assign dec.ir = ir;
assign dec.npc = npc;
assign dec.sr1 = sr1;
assign dec.sr2 = sr2;
assign dec.cc = cc_in;

// Split LDI/STI is rewritten in place, otherwise take the new instruction.
always_comb
begin
    if (rewrite_en)
    begin
        id_ex_d = id_ex_q;
        id_ex_d.opcode = rw_opcode;
        id_ex_d.addr2_sel = rw_addr2_sel;
        id_ex_d.mem_read = rw_mem_read;
        id_ex_d.mem_write = rw_mem_write;
        id_ex_d.load_cc = rw_load_cc;
        id_ex_d.load_regfile = rw_load_regfile;
        id_ex_d.indirect = rw_indirect;
    end
    else
    begin
        id_ex_d = dec;
    end
end

lc3b_stage_reg #(.payload_t(id_ex_t)) id_ex
(
    .clk(clk),
    .reset(reset),
    .hold(stall),
    .d(id_ex_d),
    .q(id_ex_q)
);

lc3b_alu #(.width(width)) alu
(
    .aluop(id_ex_q.aluop),
    .a(id_ex_q.sr1),
    .b(alu_b),
    .f(alu_result)
);

lc3b_execute #(.width(width)) execute
(
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .opcode(id_ex_q.opcode),
    .sr2_sel(id_ex_q.sr2_sel),
    .addr1_sel(id_ex_q.addr1_sel),
    .trap_sel(id_ex_q.trap_sel),
    .lshf_enable(id_ex_q.lshf_enable),
    .addr2_sel(id_ex_q.addr2_sel),
    .mem_read(id_ex_q.mem_read),
    .mem_write(id_ex_q.mem_write),
    .load_cc(id_ex_q.load_cc),
    .load_regfile(id_ex_q.load_regfile),
    .branch(id_ex_q.branch),
    .dr(id_ex_q.dr),
    .ir(id_ex_q.ir),
    .npc(id_ex_q.npc),
    .sr1(id_ex_q.sr1),
    .sr2(id_ex_q.sr2),
    .cc(id_ex_q.cc),
    .indirect(id_ex_q.indirect),
    .valid_in(id_ex_q.valid),
    .alu_result(alu_result),
    .alu_b(alu_b),
    .address(ex_mem_d.address),
    .rw_opcode(rw_opcode),
    .rw_addr2_sel(rw_addr2_sel),
    .rw_mem_read(rw_mem_read),
    .rw_mem_write(rw_mem_write),
    .rw_load_cc(rw_load_cc),
    .rw_load_regfile(rw_load_regfile),
    .rw_indirect(rw_indirect),
    .rewrite_en(rewrite_en),
    .ex_indirect_stall(ex_indirect_stall),
    .ex_valid(ex_mem_d.valid),
    .ex_opcode(ex_mem_d.opcode),
    .ex_mem_read(ex_mem_d.mem_read),
    .ex_mem_write(ex_mem_d.mem_write),
    .ex_indirect(ex_mem_d.indirect),
    .ex_load_cc(ex_mem_d.load_cc),
    .ex_load_regfile(ex_mem_d.load_regfile),
    .ex_br_request(ex_mem_d.br_request),
    .ex_dr(ex_mem_d.dr),
    .ex_result(ex_mem_d.result),
    .ex_npc(ex_mem_d.npc),
    .ex_cc(ex_mem_d.cc)
);

lc3b_stage_reg #(.payload_t(ex_mem_t)) ex_mem
(
    .clk(clk),
    .reset(reset),
    .hold(stall),
    .d(ex_mem_d),
    .q(ex_mem_q)
);

assign valid = ex_mem_q.valid;
assign opcode = ex_mem_q.opcode;
assign mem_read = ex_mem_q.mem_read;
assign mem_write = ex_mem_q.mem_write;
assign indirect = ex_mem_q.indirect;
assign load_cc = ex_mem_q.load_cc;
assign load_regfile = ex_mem_q.load_regfile;
assign br_request = ex_mem_q.br_request;
assign dr = ex_mem_q.dr;
assign result = ex_mem_q.result;
assign address = ex_mem_q.address;
assign npc_out = ex_mem_q.npc;
assign cc_out = ex_mem_q.cc;

endmodule : lc3b_ex_pipeline

//--- verification/lc3b_ex_checker.sv
`timescale 1ns/1ns

module lc3b_ex_checker
(
    input logic clk,
    input logic reset,
    input logic stall,
    input logic valid_in,
    input logic valid,
    input logic [3:0] opcode,
    input logic mem_read,
    input logic mem_write,
    input logic indirect,
    input logic load_cc,
    input logic load_regfile,
    input logic br_request,
    input logic [2:0] dr,
    input logic [15:0] result,
    input logic [15:0] address,
    input logic [15:0] npc_out,
    input logic [2:0] cc_out,
    input logic ex_indirect_stall,
    output int items_checked,
    output int errors
);

// Flags are mem_read, mem_write, indirect, load_cc, load_regfile, br_request.
typedef struct packed {
    logic [3:0] opcode;
    logic [5:0] flags;
    logic [2:0] dr;
    logic [15:0] result;
    logic [15:0] address;
    logic [15:0] npc;
    logic [2:0] cc;
} exp_item_t;

exp_item_t exp_q[$];
logic ex_mem_loaded = 1'b0;
logic reset_seen = 1'b0;
logic started = 1'b0;
logic split_seen = 1'b0;

initial
begin
    items_checked = 0;
    errors = 0;
end

task automatic expect_item(input logic [3:0] op, input logic [5:0] flags,
                           input logic [2:0] d, input logic [15:0] res,
                           input logic [15:0] addr, input logic [15:0] np,
                           input logic [2:0] c);
    exp_item_t item;
    item = '{op, flags, d, res, addr, np, c};
    exp_q.push_back(item);
endtask

task automatic compare_field(input string name, input logic [15:0] got,
                             input logic [15:0] want);
    if (got !== want)
    begin
        errors++;
        $display("** Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, want, got);
    end
endtask

task automatic check_idle();
    compare_field("valid", valid, 1'b0);
    compare_field("mem_read", mem_read, 1'b0);
    compare_field("mem_write", mem_write, 1'b0);
    compare_field("load_cc", load_cc, 1'b0);
    compare_field("load_regfile", load_regfile, 1'b0);
    compare_field("br_request", br_request, 1'b0);
    compare_field("ex_indirect_stall", ex_indirect_stall, 1'b0);
endtask

// EX/MEM takes a new item on every rising edge without stall.
always @(posedge clk)
begin
    ex_mem_loaded <= !reset && !stall;
    if (reset)
        reset_seen <= 1'b1;
    else if (valid_in && !stall)
        started <= 1'b1;
end

// Registered outputs are settled by the falling edge.
always @(negedge clk)
begin
    exp_item_t want;
    if (reset_seen && !started)
        check_idle();
    if (reset_seen && !valid)
    begin
        compare_field("load_cc", load_cc, 1'b0);
        compare_field("load_regfile", load_regfile, 1'b0);
        compare_field("br_request", br_request, 1'b0);
    end
    if (ex_mem_loaded && valid)
    begin
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("Unexpected output item at %0t ns, no expected record is left", $time);
        end
        else
        begin
            want = exp_q.pop_front();
            compare_field("opcode", opcode, want.opcode);
            compare_field("mem_read", mem_read, want.flags[5]);
            compare_field("mem_write", mem_write, want.flags[4]);
            compare_field("indirect", indirect, want.flags[3]);
            compare_field("load_cc", load_cc, want.flags[2]);
            compare_field("load_regfile", load_regfile, want.flags[1]);
            compare_field("br_request", br_request, want.flags[0]);
            compare_field("dr", dr, want.dr);
            compare_field("result", result, want.result);
            compare_field("address", address, want.address);
            compare_field("npc_out", npc_out, want.npc);
            compare_field("cc_out", cc_out, want.cc);
            if (indirect)
            begin
                if (!split_seen)
                begin
                    errors++;
                    $display("Indirect item at %0t ns came without ex_indirect_stall", $time);
                end
                split_seen = 1'b0;
            end
            items_checked++;
        end
    end
    if (ex_indirect_stall)
        split_seen = 1'b1;
end

endmodule : lc3b_ex_checker

//--- verification/tb_lc3b_ex_pipeline.sv
`timescale 1ns/1ns

module tb_lc3b_ex_pipeline
    import lc3b_pkg::*;
();

localparam int rec_words = 9;
localparam int max_recs = 64;
localparam int num_tests = 5;
localparam int stress_test = 5;

logic clk;
logic reset;
lc3b_word ir;
lc3b_word npc;
lc3b_word sr1;
lc3b_word sr2;
lc3b_nzp cc_in;
logic valid_in;
logic stall;

logic valid;
lc3b_opcode opcode;
logic mem_read;
logic mem_write;
logic indirect;
logic load_cc;
logic load_regfile;
logic br_request;
lc3b_reg dr;
lc3b_word result;
lc3b_word address;
lc3b_word npc_out;
lc3b_nzp cc_out;
logic ex_indirect_stall;

int items_checked;
int errors;

logic [31:0] recs [0:rec_words*max_recs-1];
int exp_per_test [0:num_tests];
int cycle_count = 0;
int cycle_limit = 0;
int tests_failed = 0;
logic random_stalls = 1'b0;

lc3b_ex_pipeline #(.width(16)) UUT
(
    .clk(clk),
    .reset(reset),
    .ir(ir),
    .npc(npc),
    .sr1(sr1),
    .sr2(sr2),
    .cc_in(cc_in),
    .valid_in(valid_in),
    .stall(stall),
    .valid(valid),
    .opcode(opcode),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .indirect(indirect),
    .load_cc(load_cc),
    .load_regfile(load_regfile),
    .br_request(br_request),
    .dr(dr),
    .result(result),
    .address(address),
    .npc_out(npc_out),
    .cc_out(cc_out),
    .ex_indirect_stall(ex_indirect_stall)
);

lc3b_ex_checker check
(
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .valid_in(valid_in),
    .valid(valid),
    .opcode(opcode),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .indirect(indirect),
    .load_cc(load_cc),
    .load_regfile(load_regfile),
    .br_request(br_request),
    .dr(dr),
    .result(result),
    .address(address),
    .npc_out(npc_out),
    .cc_out(cc_out),
    .ex_indirect_stall(ex_indirect_stall),
    .items_checked(items_checked),
    .errors(errors)
);

initial
begin
    clk = 1'b0;
    forever
        #2 clk = ~clk;
end

function automatic string test_name(input int t);
    case (t)
        0: return "reset";
        1: return "alu";
        2: return "addresses";
        3: return "indirect split";
        4: return "valid gating";
        default: return "back-pressure";
    endcase
endfunction

task automatic load_records();
    int i;
    int b;
    int num_records;
    int total_stalls;
    num_records = 0;
    total_stalls = 0;
    for (i = 0; i < rec_words * max_recs; i++)
        recs[i] = '0;
    for (i = 0; i <= num_tests; i++)
        exp_per_test[i] = 0;
    $readmemh("verification/ex_pipeline_input.txt", recs);
    for (i = 0; i < max_recs; i++)
    begin
        b = i * rec_words;
        if (recs[b] == 32'd1)
        begin
            num_records++;
            total_stalls += recs[b+8];
        end
        else if (recs[b] == 32'd2)
        begin
            num_records++;
            exp_per_test[recs[b+1]]++;
            check.expect_item(recs[b+2][3:0],
                {recs[b+3][20], recs[b+3][16], recs[b+3][12],
                 recs[b+3][8], recs[b+3][4], recs[b+3][0]},
                recs[b+4][2:0], recs[b+5][15:0], recs[b+6][15:0],
                recs[b+7][15:0], recs[b+8][2:0]);
        end
    end
    if (num_records == 0)
    begin
        tests_failed++;
        $display("No records were read from verification/ex_pipeline_input.txt");
    end
    cycle_limit = 4 * num_records + total_stalls + 100;
endtask

// Called on a falling edge, returns on the falling edge after acceptance.
task automatic drive_record(input int b);
    int stalls_left;
    logic accepted;
    stalls_left = recs[b+8];
    ir = recs[b+2][15:0];
    npc = recs[b+3][15:0];
    sr1 = recs[b+4][15:0];
    sr2 = recs[b+5][15:0];
    cc_in = recs[b+6][2:0];
    valid_in = recs[b+7][0];
    accepted = 1'b0;
    while (!accepted)
    begin
        if (stalls_left > 0)
        begin
            stall = 1'b1;
            stalls_left--;
        end
        else if (random_stalls && ($urandom % 4 == 0))
            stall = 1'b1;
        else
            stall = 1'b0;
        // An unsplit LDI or STI in ID/EX keeps decode waiting.
        accepted = !stall && !ex_indirect_stall;
        @(negedge clk);
    end
endtask

task automatic drain(input int total);
    valid_in = 1'b0;
    stall = 1'b0;
    ir = '0;
    while (items_checked < total)
        @(posedge clk);
    // Two stages plus the split cycle, so a stray item would appear by now.
    repeat (3) @(posedge clk);
endtask

task automatic report_test(input int t, input int items_before, input int errors_before);
    int new_errors;
    new_errors = errors - errors_before;
    if (new_errors != 0)
        tests_failed++;
    $display("test %0d %s: %0d items, %0d errors, %s", t, test_name(t),
             items_checked - items_before, new_errors, (new_errors == 0) ? "ok" : "failed");
endtask

initial
begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit)
    begin
        @(posedge clk);
        cycle_count++;
    end
    $display("Timeout after %0d cycles, expected output items never arrived", cycle_count);
    $display(">>> FAIL");
    $finish;
end

initial
begin
    int seed;
    int t;
    int i;
    int b;
    int exp_total;
    int items_before;
    int errors_before;
    seed = $urandom(32'hf4a6);
    reset = 1'b1;
    ir = '0;
    npc = '0;
    sr1 = '0;
    sr2 = '0;
    cc_in = '0;
    valid_in = 1'b0;
    stall = 1'b0;
    load_records();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    items_before = items_checked;
    errors_before = errors;
    repeat (2) @(posedge clk);
    report_test(0, items_before, errors_before);
    items_before = items_checked;
    errors_before = errors;
    @(negedge clk);
    exp_total = 0;
    for (t = 1; t <= num_tests; t++)
    begin
        random_stalls = (t == stress_test);
        for (i = 0; i < max_recs; i++)
        begin
            b = i * rec_words;
            if (recs[b] == 32'd1 && recs[b+1] == t)
                drive_record(b);
        end
        exp_total += exp_per_test[t];
        drain(exp_total);
        report_test(t, items_before, errors_before);
        items_before = items_checked;
        errors_before = errors;
        @(negedge clk);
    end
    @(posedge clk);
    $display("%0d tests, %0d failed, %0d items checked, %0d errors",
             num_tests + 1, tests_failed, items_checked, errors);
    if (errors == 0 && tests_failed == 0)
        $display(">>> PASS");
    else
        $display(">>> FAIL");
    $finish;
end

endmodule : tb_lc3b_ex_pipeline

//--- verification/ex_pipeline_input.txt
// kind 1 stimulus: kind test ir npc sr1 sr2 cc valid_in stall_cycles
// kind 2 expected: kind test opcode flags dr result address npc_out cc_out
// flags digits: mem_read mem_write indirect load_cc load_regfile br_request
// ALU
1 1 1283 3000 0005 0007 2 1 0
2 1 1 000110 1 000C 3000 3000 2
1 1 14BD 3000 0010 1234 2 1 0
2 1 1 000110 2 000D 3000 3000 2
1 1 5705 3000 F0F0 3C3C 2 1 0
2 1 5 000110 3 3030 3000 3000 2
1 1 592F 3000 ABCD 0000 2 1 0
2 1 5 000110 4 000D 3000 3000 2
1 1 9BBF 3000 00FF 0000 2 1 0
2 1 9 000110 5 FF00 3000 3000 2
1 1 DC44 3000 1234 0000 2 1 0
2 1 D 000110 6 2340 3000 3000 2
1 1 DE53 3000 8010 0000 2 1 0
2 1 D 000110 7 1002 3000 3000 2
1 1 D072 3000 8010 0000 2 1 0
2 1 D 000110 0 E004 3000 3000 2
// LEA, BR, JSR, LDR, STB, TRAP
1 2 E410 3000 0000 0000 2 1 0
2 2 E 000010 2 3020 3020 3000 2
1 2 0FFC 3000 4444 0000 2 1 0
2 2 0 000001 7 4444 2FF8 3000 2
1 2 4900 3000 5555 0000 2 1 0
2 2 4 000011 7 3000 3200 3000 2
1 2 6283 3000 4000 0000 2 1 0
2 2 6 100110 1 4000 4006 3000 2
1 2 373F 3000 5000 0000 2 1 0
2 2 3 010000 3 5000 4FFF 3000 2
1 2 F025 3000 0000 0000 2 1 0
2 2 F 100011 7 3000 004A 3000 2
// LDI and STI each give a pointer read, then the rewritten access
1 3 AB82 3000 6000 0000 2 1 0
2 3 A 100000 5 6000 6004 3000 2
2 3 6 101110 5 6000 6000 3000 2
1 3 B2BE 3000 7000 0000 2 1 0
2 3 B 100000 1 7000 6FFC 3000 2
2 3 7 011000 1 7000 7000 3000 2
// Bubbles produce no items
1 4 1283 3000 0005 0007 2 0 0
1 4 0FFC 3000 4444 0000 2 0 0
1 4 F025 3000 0000 0000 2 0 0
1 4 9BBF 3000 1234 0000 2 1 0
2 4 9 000110 5 EDCB 3000 3000 2
// Stalled mix
1 5 14BD 3100 0010 0000 4 1 2
2 5 1 000110 2 000D 3100 3100 4
1 5 AB82 3100 6000 0000 4 1 3
2 5 A 100000 5 6000 6004 3100 4
2 5 6 101110 5 6000 6000 3100 4
1 5 F025 3100 0000 0000 4 1 0
2 5 F 100011 7 3100 004A 3100 4
1 5 B2BE 3100 7000 0000 4 1 1
2 5 B 100000 1 7000 6FFC 3100 4
2 5 7 011000 1 7000 7000 3100 4

//--- project.f
verilog/lc3b_pkg.sv
verilog/lc3b_decode.sv
verilog/lc3b_stage_reg.sv
verilog/lc3b_alu.sv
verilog/lc3b_execute.sv
verilog/lc3b_ex_pipeline.sv
verification/lc3b_ex_checker.sv
verification/tb_lc3b_ex_pipeline.sv

//--- Bender.yml
package:
  name: lc3b_ex_pipeline

sources:
  - verilog/lc3b_pkg.sv
  - verilog/lc3b_decode.sv
  - verilog/lc3b_stage_reg.sv
  - verilog/lc3b_alu.sv
  - verilog/lc3b_execute.sv
  - verilog/lc3b_ex_pipeline.sv
  - target: test
    files:
      - verification/lc3b_ex_checker.sv
      - verification/tb_lc3b_ex_pipeline.sv
